//--- verilog.f
uart_pkg.sv
uart_baud_gen.sv
uart_rx.sv
uart_tx.sv
uart_apb_regs.sv
uart_top.sv
tb_uart.sv

//--- tb_uart.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart;
    import uart_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int MAX_DIV     = 3;
    localparam int FRAME_CYC   = 10 * 16 * (MAX_DIV + 1);  // worst-case frame
    localparam int NUM_FRAMES  = 16;                        // frames over all tests, rounded up
    localparam int WATCHDOG_NS = 2 * NUM_FRAMES * FRAME_CYC * CLK_PERIOD;

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      line_rx;   // serial line model output
    logic      loopback;
    logic      rx_mux;
    logic      tx;
    logic      irq;
    logic [31:0] lfsr_q;
    div_t      cur_div;
    int        err_cnt;
    int        test_cnt;
    int        fail_cnt;

    assign rx_mux = loopback ? tx : line_rx;

    uart_top u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr),
        .rx     (rx_mux),
        .tx     (tx),
        .irq    (irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic byte_t next_byte();
        byte_t b;
        for (int i = 0; i < 8; i++) begin
            b[i] = next_bit();
        end
        return b;
    endfunction

    function automatic int bit_cycles();
        return (int'(cur_div) + 1) * 16;
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #10;
        rdata = prdata;  // settled well before the completing edge
        err   = pslverr;
        if (!pready) begin
            err_cnt++;
            $display("pready was low during an access cycle");
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic set_divisor(input div_t d);
        logic err;
        apb_write(ADDR_DIV, apb_data_t'(d), err);
        check_bit("pslverr", err, 1'b0);
        cur_div = d;
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic drive_bit(input logic v, input int cycles);
        line_rx = v;
        repeat (cycles) @(posedge clk);
        #2;
    endtask

    task automatic send_frame(input byte_t data, input logic stop);
        int n;
        n = bit_cycles();
        @(posedge clk);
        #2;
        drive_bit(1'b0, n);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i], n);
        end
        drive_bit(stop, n);
        line_rx = 1'b1;
    endtask

    task automatic wait_irq(input int max_cyc);
        int n;
        n = 0;
        while (!irq && n < max_cyc) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!irq) begin
            err_cnt++;
            $display("timed out waiting for the received-data interrupt");
        end
    endtask

    task automatic receive_one(input byte_t b);
        apb_data_t d;
        logic      err;
        send_frame(b, 1'b1);
        wait_irq(bit_cycles());
        check_bit("irq", irq, 1'b1);
        apb_read(ADDR_DATA, d, err);
        check_byte("rx_data", d[7:0], b);
        check_bit("irq", irq, 1'b0);
        apb_read(ADDR_STATUS, d, err);
        check_word("status", d, 32'h0);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic test_reset_regs();
        int        e;
        apb_data_t d;
        logic      err;
        e = err_cnt;
        apb_read(ADDR_STATUS, d, err);
        check_word("status", d, 32'h0);
        check_bit("pslverr", err, 1'b0);
        apb_read(ADDR_DIV, d, err);
        check_word("divisor", d, 32'h1);
        check_bit("tx", tx, 1'b1);
        check_bit("irq", irq, 1'b0);
        apb_write(ADDR_DIV, 32'h0000_1234, err);
        check_bit("pslverr", err, 1'b0);
        apb_read(ADDR_DIV, d, err);
        check_word("divisor", d, 32'h0000_1234);
        apb_read(8'h0c, d, err);
        check_bit("pslverr", err, 1'b1);
        apb_write(8'h10, 32'h0, err);
        check_bit("pslverr", err, 1'b1);
        set_divisor(16'd1);
        end_test("reset and registers", e);
    endtask

    task automatic test_line_rx();
        int e;
        e = err_cnt;
        for (int k = 0; k < 2; k++) begin
            set_divisor(k == 0 ? 16'd1 : 16'd3);
            repeat (3) receive_one(next_byte());
        end
        set_divisor(16'd1);
        end_test("line reception", e);
    endtask

    task automatic test_loopback();
        int        e;
        int        n;
        byte_t     b;
        apb_data_t d;
        logic      err;
        e = err_cnt;
        loopback = 1'b1;
        repeat (2) begin
            b = next_byte();
            apb_write(ADDR_DATA, apb_data_t'(b), err);
            check_bit("pslverr", err, 1'b0);
            apb_read(ADDR_STATUS, d, err);
            check_bit("tx_busy", d[STAT_TX_BUSY], 1'b1);
            apb_write(ADDR_DATA, apb_data_t'(~b), err);  // must be refused
            check_bit("pslverr", err, 1'b1);
            wait_irq(12 * bit_cycles());
            apb_read(ADDR_DATA, d, err);
            check_byte("rx_data", d[7:0], b);
            n = 0;
            do begin
                apb_read(ADDR_STATUS, d, err);
                n++;
            end while (d[STAT_TX_BUSY] && n < bit_cycles());
            if (d[STAT_TX_BUSY]) begin
                err_cnt++;
                $display("transmitter stayed busy after the frame");
            end
            check_bit("rx_valid", d[STAT_RX_VALID], 1'b0);
            // a refused byte must never come out on the line
            repeat (12 * bit_cycles()) @(posedge clk);
            #2;
            check_bit("irq", irq, 1'b0);
        end
        loopback = 1'b0;
        end_test("loopback", e);
    endtask

    task automatic test_framing();
        int        e;
        apb_data_t d;
        logic      err;
        e = err_cnt;
        send_frame(next_byte(), 1'b0);
        apb_read(ADDR_STATUS, d, err);
        check_word("status", d, 32'h8);
        apb_read(ADDR_STATUS, d, err);
        check_word("status", d, 32'h0);
        drive_bit(1'b1, bit_cycles());
        check_bit("irq", irq, 1'b0);
        end_test("framing error", e);
    endtask

    task automatic test_overrun();
        int        e;
        byte_t     b0;
        byte_t     b1;
        apb_data_t d;
        logic      err;
        e = err_cnt;
        b0 = next_byte();
        b1 = next_byte();
        send_frame(b0, 1'b1);
        send_frame(b1, 1'b1);
        apb_read(ADDR_STATUS, d, err);
        check_word("status", d, 32'h5);  // rx_valid and overrun
        apb_read(ADDR_DATA, d, err);
        check_byte("rx_data", d[7:0], b0);
        apb_read(ADDR_STATUS, d, err);
        check_word("status", d, 32'h0);
        end_test("overrun", e);
    endtask

    task automatic test_glitch();
        int        e;
        apb_data_t d;
        logic      err;
        e = err_cnt;
        @(posedge clk);
        #2;
        drive_bit(1'b0, bit_cycles() / 4);
        drive_bit(1'b1, 2 * bit_cycles());
        check_bit("irq", irq, 1'b0);
        apb_read(ADDR_STATUS, d, err);
        check_word("status", d, 32'h0);
        receive_one(next_byte());
        end_test("start-bit glitch", e);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        line_rx  = 1'b1;
        loopback = 1'b0;
        lfsr_q   = 32'h05b9_cb6d;
        cur_div  = 16'd1;
        err_cnt  = 0;
        test_cnt = 0;
        fail_cnt = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_regs();
        test_line_rx();
        test_loopback();
        test_framing();
        test_overrun();
        test_glitch();
        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_top #(
    parameter int DIV_WIDTH = $bits(uart_pkg::div_t)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  uart_pkg::apb_addr_t paddr,
    input  uart_pkg::apb_data_t pwdata,
    output uart_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                rx,
    output logic                tx,
    output logic                irq
);
    import uart_pkg::*;

    logic                 tick;
    logic [DIV_WIDTH-1:0] divisor;
    byte_t                rx_data;
    logic                 rx_done;
    logic                 rx_frame_err;
    logic                 tx_start;
    byte_t                tx_data;
    logic                 tx_busy;

    uart_baud_gen #(
        .DIV_WIDTH(DIV_WIDTH)
    ) u_baud_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .divisor(divisor),
        .tick   (tick)
    );

    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick        (tick),
        .rx          (rx),
        .rx_data     (rx_data),
        .rx_done     (rx_done),
        .rx_frame_err(rx_frame_err)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .tx_start(tx_start),
        .tx_data (tx_data),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

    uart_apb_regs #(
        .DIV_WIDTH(DIV_WIDTH)
    ) u_apb_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .rx_data     (rx_data),
        .rx_done     (rx_done),
        .rx_frame_err(rx_frame_err),
        .tx_busy     (tx_busy),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .divisor     (divisor),
        .irq         (irq)
    );

endmodule

`default_nettype wire

//--- uart_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module uart_apb_regs #(
    parameter int DIV_WIDTH = $bits(uart_pkg::div_t)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  uart_pkg::apb_addr_t  paddr,
    input  uart_pkg::apb_data_t  pwdata,
    input  uart_pkg::byte_t      rx_data,
    input  logic                 rx_done,
    input  logic                 rx_frame_err,
    input  logic                 tx_busy,
    output uart_pkg::apb_data_t  prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 tx_start,
    output uart_pkg::byte_t      tx_data,
    output logic [DIV_WIDTH-1:0] divisor,
    output logic                 irq
);
    import uart_pkg::*;

    logic  access;
    logic  wr_access;
    logic  rd_access;
    logic  addr_hit;
    logic  wr_data;
    logic  rd_data;
    logic  rd_status;
    logic  rx_valid;
    logic  overrun;
    logic  frame_err;
    byte_t rx_byte;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;
    assign addr_hit  = (paddr == ADDR_DATA) || (paddr == ADDR_STATUS) || (paddr == ADDR_DIV);

    assign wr_data   = wr_access && (paddr == ADDR_DATA) && !tx_busy;
    assign rd_data   = rd_access && (paddr == ADDR_DATA);
    assign rd_status = rd_access && (paddr == ADDR_STATUS);

    // no wait states; error on a bad offset or a data write while sending
    assign pready  = 1'b1;
    assign pslverr = access && (!addr_hit || (pwrite && (paddr == ADDR_DATA) && tx_busy));
    assign irq     = rx_valid;

    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_DATA: prdata[7:0] = rx_byte;
            ADDR_STATUS: begin
                prdata[STAT_RX_VALID]  = rx_valid;
                prdata[STAT_TX_BUSY]   = tx_busy;
                prdata[STAT_OVERRUN]   = overrun;
                prdata[STAT_FRAME_ERR] = frame_err;
            end
            ADDR_DIV: prdata[DIV_WIDTH-1:0] = divisor;
            default: prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_start <= 1'b0;
            divisor  <= DIV_WIDTH'(1);
        end else begin
            tx_start <= wr_data;  // one-cycle pulse to the transmitter
            if (wr_access && (paddr == ADDR_DIV)) begin
                divisor <= pwdata[DIV_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_data) begin
            tx_data <= pwdata[7:0];
        end
    end

    // flags, a new event wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            if (rd_data) begin
                rx_valid <= 1'b0;
            end
            if (rd_status) begin
                overrun   <= 1'b0;
                frame_err <= 1'b0;
            end
            if (rx_done) begin
                if (rx_valid && !rd_data) begin
                    overrun <= 1'b1;  // held byte kept
                end else begin
                    rx_valid <= 1'b1;
                end
            end
            if (rx_frame_err) begin
                frame_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done && (!rx_valid || rd_data)) begin
            rx_byte <= rx_data;
        end
    end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tick,
    input  logic            tx_start,
    input  uart_pkg::byte_t tx_data,
    output logic            tx,
    output logic            tx_busy
);
    import uart_pkg::*;

    tx_state_t  state;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    byte_t      shift_q;
    logic       load;
    logic       bit_end;

    assign load    = (state == TX_IDLE) && tx_start && !tx_busy;
    assign bit_end = tick && (tick_cnt == 4'd15);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    if (load) begin
                        tx_busy <= 1'b1;  // byte taken, wait for the next tick
                    end else if (tx_busy && tick) begin
                        state <= TX_START;
                        tx    <= 1'b0;
                    end
                end
                TX_START: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_end) begin
                        state <= TX_DATA;
                        tx    <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            state <= TX_STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shift_q[1];  // next bit, shift happens this edge
                        end
                    end
                end
                TX_STOP: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_end) begin
                        state   <= TX_IDLE;
                        tx_busy <= 1'b0;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tx_data;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tick,
    input  logic            rx,
    output uart_pkg::byte_t rx_data,
    output logic            rx_done,
    output logic            rx_frame_err
);
    import uart_pkg::*;

    logic       rx_meta;
    logic       rx_sync;
    rx_state_t  state;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    byte_t      shift_q;
    logic       bit_centre;

    assign bit_centre = tick && (tick_cnt == 4'd15);  // 16 ticks after the previous sample

    // line idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= RX_IDLE;
            tick_cnt     <= '0;
            bit_cnt      <= '0;
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;  // falling edge, possible start bit
                    end
                end
                RX_START: begin
                    if (tick) begin
                        if (tick_cnt == 4'd7) begin
                            tick_cnt <= '0;
                            // high again at mid-bit means it was a glitch
                            state    <= rx_sync ? RX_IDLE : RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;  // wraps to 0 at the centre
                    end
                    if (bit_centre) begin
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_centre) begin
                        rx_done      <= rx_sync;
                        rx_frame_err <= !rx_sync;  // stop bit read low
                        state        <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data path, lsb arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_centre) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
        if (state == RX_STOP && bit_centre && rx_sync) begin
            rx_data <= shift_q;  // only good frames are delivered
        end
    end

endmodule

`default_nettype wire

//--- uart_baud_gen.sv
`timescale 1ns/1ns
`default_nettype none

module uart_baud_gen #(
    parameter int DIV_WIDTH = $bits(uart_pkg::div_t)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [DIV_WIDTH-1:0] divisor,
    output logic                 tick
);

    logic [DIV_WIDTH-1:0] cnt;
    logic [DIV_WIDTH-1:0] div_q;  // last divisor seen, to catch a rate change

    // one tick every divisor+1 cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt   <= '0;
            div_q <= '0;
            tick  <= 1'b0;
        end else begin
            div_q <= divisor;
            if (divisor != div_q) begin
                cnt  <= divisor;  // new rate, restart the period
                tick <= 1'b0;
            end else if (cnt == '0) begin
                cnt  <= divisor;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt - 1'b1;
                tick <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [7:0]  byte_t;      // one serial data byte
    typedef logic [15:0] div_t;       // baud divisor
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t ADDR_DATA   = 8'h00;
    localparam apb_addr_t ADDR_STATUS = 8'h04;
    localparam apb_addr_t ADDR_DIV    = 8'h08;

    // bit positions in the status word
    localparam int STAT_RX_VALID  = 0;
    localparam int STAT_TX_BUSY   = 1;
    localparam int STAT_OVERRUN   = 2;
    localparam int STAT_FRAME_ERR = 3;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire
